/* run_sim.sh */
#!/bin/sh
# build and run the memory bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mem_bridge_tb -f verilog.f -o mem_bridge_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mem_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* src/axi_read_engine.sv */
`timescale 1ns/1ps

module axi_read_engine import mem_bus_pkg::*; (
    input  logic    aclk,
    input  logic    rst,
    input  rd_cmd_t cmd_i,
    input  logic    cmd_valid_i,
    input  logic    arready_i,
    input  axi_r_t  r_i,
    input  logic    rvalid_i,
    output axi_ar_t ar_o,
    output logic    arvalid_o,
    output logic    rready_o,
    output logic    rd_done_o,
    output line_t   rd_data_o
);
    logic          idle;
    logic          r_fire;
    logic [2:0]    beat_cnt;
    line_t         line_q;
    axi_ar_t       next_ar;

    // arvalid and rready double as the engine state
    assign idle   = !arvalid_o && !rready_o;
    assign r_fire = rvalid_i && rready_o;

    always_comb begin
        next_ar.size  = beat_size;
        next_ar.burst = burst_incr;
        if (cmd_i.is_line) begin
            next_ar.addr = {cmd_i.addr[addr_w-1:line_off_w], {line_off_w{1'b0}}};
            next_ar.len  = line_len;
        end else begin
            next_ar.addr = cmd_i.addr;
            next_ar.len  = word_len;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            arvalid_o <= 1'b0;
            rready_o  <= 1'b0;
            rd_done_o <= 1'b0;
            beat_cnt  <= 3'd0;
        end else begin
            rd_done_o <= 1'b0;
            if (idle && cmd_valid_i) begin
                arvalid_o <= 1'b1;
                beat_cnt  <= 3'd0;
            end
            if (arvalid_o && arready_i) begin
                arvalid_o <= 1'b0;
                rready_o  <= 1'b1;
            end
            if (r_fire) begin
                beat_cnt <= beat_cnt + 3'd1;
                if (r_i.last) begin
                    rready_o  <= 1'b0;
                    rd_done_o <= 1'b1;
                end
            end
        end
    end

    // payload regs
    always_ff @(posedge aclk) begin
        if (idle && cmd_valid_i) begin
            ar_o <= next_ar;
        end
        if (r_fire) begin
            line_q[beat_cnt*word_w +: word_w] <= r_i.data;
        end
    end

    assign rd_data_o = line_q;

    a_ar_stable: assert property (@(posedge aclk) disable iff (rst)
        arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

    // last on beat 8 for a line, beat 1 for a word
    a_r_last: assert property (@(posedge aclk) disable iff (rst)
        r_fire |-> (r_i.last == ({5'd0, beat_cnt} == ar_o.len)));

endmodule

/* src/axi_write_engine.sv */
`timescale 1ns/1ps

module axi_write_engine import mem_bus_pkg::*; (
    input  logic                aclk,
    input  logic                rst,
    input  logic                dcache_wr_req_i,
    input  logic [addr_w-1:0]   dcache_wr_addr_i,
    input  line_t               dcache_wr_data_i,
    input  logic                ducache_wen_i,
    input  logic [addr_w-1:0]   ducache_awaddr_i,
    input  logic [word_w-1:0]   ducache_wdata_i,
    input  logic [word_w/8-1:0] ducache_strb_i,
    input  logic                awready_i,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                dcache_wr_done_o,
    output logic                ducache_bvalid_o,
    output axi_aw_t             aw_o,
    output logic                awvalid_o,
    output axi_w_t              w_o,
    output logic                wvalid_o,
    output logic                bready_o
);
    logic    sel_line;   // current burst is a line writeback
    logic    idle;
    logic    start;
    logic [2:0] beat_cnt;
    logic [2:0] nxt_idx;
    axi_aw_t next_aw;
    axi_w_t  next_w;

    // hold off while a completion pulse is out, the client still has req up
    assign idle  = !awvalid_o && !wvalid_o && !bready_o
                   && !dcache_wr_done_o && !ducache_bvalid_o;
    assign start = idle && (dcache_wr_req_i || ducache_wen_i);

    always_comb begin
        next_aw.size  = beat_size;
        next_aw.burst = burst_incr;
        if (dcache_wr_req_i) begin
            next_aw.addr = {dcache_wr_addr_i[addr_w-1:line_off_w], {line_off_w{1'b0}}};
            next_aw.len  = line_len;
        end else begin
            next_aw.addr = ducache_awaddr_i;
            next_aw.len  = word_len;
        end
    end

    // beat 0 right after AW, then one up per W handshake
    assign nxt_idx = awvalid_o ? 3'd0 : beat_cnt + 3'd1;

    always_comb begin
        if (sel_line) begin
            next_w.data = dcache_wr_data_i[nxt_idx*word_w +: word_w];
            next_w.strb = strb_all;
            next_w.last = (nxt_idx == 3'(line_words - 1));
        end else begin
            next_w.data = ducache_wdata_i;
            next_w.strb = ducache_strb_i;
            next_w.last = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            awvalid_o        <= 1'b0;
            wvalid_o         <= 1'b0;
            bready_o         <= 1'b0;
            sel_line         <= 1'b0;
            beat_cnt         <= 3'd0;
            dcache_wr_done_o <= 1'b0;
            ducache_bvalid_o <= 1'b0;
        end else begin
            dcache_wr_done_o <= 1'b0;
            ducache_bvalid_o <= 1'b0;
            if (start) begin
                awvalid_o <= 1'b1;
                sel_line  <= dcache_wr_req_i;   // writeback wins
            end
            if (awvalid_o && awready_i) begin
                awvalid_o <= 1'b0;
                wvalid_o  <= 1'b1;
                beat_cnt  <= 3'd0;
            end
            if (wvalid_o && wready_i) begin
                if (w_o.last) begin
                    wvalid_o <= 1'b0;
                    bready_o <= 1'b1;
                end else begin
                    beat_cnt <= nxt_idx;
                end
            end
            if (bready_o && bvalid_i) begin
                bready_o         <= 1'b0;
                dcache_wr_done_o <= sel_line;
                ducache_bvalid_o <= !sel_line;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (start) begin
            aw_o <= next_aw;
        end
        if ((awvalid_o && awready_i) || (wvalid_o && wready_i && !w_o.last)) begin
            w_o <= next_w;
        end
    end

    a_w_stable: assert property (@(posedge aclk) disable iff (rst)
        wvalid_o && !wready_i |=> wvalid_o && $stable(w_o));

endmodule

/* src/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top import mem_bus_pkg::*; (
    input  logic                aclk,
    input  logic                rst,
    // icache line refill
    input  logic                icache_rd_req_i,
    input  logic [addr_w-1:0]   icache_rd_addr_i,
    output logic                icache_ret_valid_o,
    output line_t               icache_ret_data_o,
    // dcache line refill and writeback
    input  logic                dcache_rd_req_i,
    input  logic [addr_w-1:0]   dcache_rd_addr_i,
    output logic                dcache_ret_valid_o,
    output line_t               dcache_ret_data_o,
    input  logic                dcache_wr_req_i,
    input  logic [addr_w-1:0]   dcache_wr_addr_i,
    input  line_t               dcache_wr_data_i,
    output logic                dcache_wr_done_o,
    // uncached data
    input  logic                ducache_ren_i,
    input  logic [addr_w-1:0]   ducache_araddr_i,
    output logic                ducache_rvalid_o,
    output logic [word_w-1:0]   ducache_rdata_o,
    input  logic                ducache_wen_i,
    input  logic [addr_w-1:0]   ducache_awaddr_i,
    input  logic [word_w-1:0]   ducache_wdata_i,
    input  logic [word_w/8-1:0] ducache_strb_i,
    output logic                ducache_bvalid_o,
    // AXI master
    output axi_ar_t             ar_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  axi_r_t              r_i,
    input  logic                rvalid_i,
    output logic                rready_o,
    output axi_aw_t             aw_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output axi_w_t              w_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);
    rd_cmd_t rd_cmd;
    logic    rd_cmd_valid;
    logic    rd_done;
    line_t   rd_data;

    read_arbiter u_read_arbiter (
        .aclk               (aclk),
        .rst                (rst),
        .icache_rd_req_i    (icache_rd_req_i),
        .icache_rd_addr_i   (icache_rd_addr_i),
        .dcache_rd_req_i    (dcache_rd_req_i),
        .dcache_rd_addr_i   (dcache_rd_addr_i),
        .ducache_ren_i      (ducache_ren_i),
        .ducache_araddr_i   (ducache_araddr_i),
        .rd_done_i          (rd_done),
        .rd_data_i          (rd_data),
        .cmd_o              (rd_cmd),
        .cmd_valid_o        (rd_cmd_valid),
        .icache_ret_valid_o (icache_ret_valid_o),
        .icache_ret_data_o  (icache_ret_data_o),
        .dcache_ret_valid_o (dcache_ret_valid_o),
        .dcache_ret_data_o  (dcache_ret_data_o),
        .ducache_rvalid_o   (ducache_rvalid_o),
        .ducache_rdata_o    (ducache_rdata_o)
    );

    axi_read_engine u_axi_read_engine (
        .aclk        (aclk),
        .rst         (rst),
        .cmd_i       (rd_cmd),
        .cmd_valid_i (rd_cmd_valid),
        .arready_i   (arready_i),
        .r_i         (r_i),
        .rvalid_i    (rvalid_i),
        .ar_o        (ar_o),
        .arvalid_o   (arvalid_o),
        .rready_o    (rready_o),
        .rd_done_o   (rd_done),
        .rd_data_o   (rd_data)
    );

    axi_write_engine u_axi_write_engine (
        .aclk             (aclk),
        .rst              (rst),
        .dcache_wr_req_i  (dcache_wr_req_i),
        .dcache_wr_addr_i (dcache_wr_addr_i),
        .dcache_wr_data_i (dcache_wr_data_i),
        .ducache_wen_i    (ducache_wen_i),
        .ducache_awaddr_i (ducache_awaddr_i),
        .ducache_wdata_i  (ducache_wdata_i),
        .ducache_strb_i   (ducache_strb_i),
        .awready_i        (awready_i),
        .wready_i         (wready_i),
        .bvalid_i         (bvalid_i),
        .dcache_wr_done_o (dcache_wr_done_o),
        .ducache_bvalid_o (ducache_bvalid_o),
        .aw_o             (aw_o),
        .awvalid_o        (awvalid_o),
        .w_o              (w_o),
        .wvalid_o         (wvalid_o),
        .bready_o         (bready_o)
    );

endmodule

/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

    localparam int addr_w     = 32;
    localparam int word_w     = 32;
    localparam int line_words = 8;
    localparam int line_off_w = 5;   // byte offset inside a 256-bit line

    // AXI burst encodings
    localparam logic [7:0] line_len   = 8'd7;
    localparam logic [7:0] word_len   = 8'd0;
    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [2:0] beat_size  = 3'b010;   // 4 bytes per beat
    localparam logic [3:0] strb_all   = 4'b1111;

    // word 0 sits in the lowest bits
    typedef logic [line_words*word_w-1:0] line_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              is_line;
    } rd_cmd_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    typedef struct packed {
        logic [word_w-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [word_w-1:0]   data;
        logic [word_w/8-1:0] strb;
        logic                last;
    } axi_w_t;

endpackage

/* src/read_arbiter.sv */
`timescale 1ns/1ps

module read_arbiter import mem_bus_pkg::*; (
    input  logic              aclk,
    input  logic              rst,
    input  logic              icache_rd_req_i,
    input  logic [addr_w-1:0] icache_rd_addr_i,
    input  logic              dcache_rd_req_i,
    input  logic [addr_w-1:0] dcache_rd_addr_i,
    input  logic              ducache_ren_i,
    input  logic [addr_w-1:0] ducache_araddr_i,
    input  logic              rd_done_i,
    input  line_t             rd_data_i,
    output rd_cmd_t           cmd_o,
    output logic              cmd_valid_o,
    output logic              icache_ret_valid_o,
    output line_t             icache_ret_data_o,
    output logic              dcache_ret_valid_o,
    output line_t             dcache_ret_data_o,
    output logic              ducache_rvalid_o,
    output logic [word_w-1:0] ducache_rdata_o
);
    logic    busy;
    logic    gnt_ic, gnt_dc, gnt_du;   // one-hot, held until rd_done_i
    logic    any_req;
    rd_cmd_t next_cmd;

    assign any_req = dcache_rd_req_i || ducache_ren_i || icache_rd_req_i;

    // fixed priority: dcache line, uncached, icache line
    always_comb begin
        if (dcache_rd_req_i) begin
            next_cmd = '{addr: dcache_rd_addr_i, is_line: 1'b1};
        end else if (ducache_ren_i) begin
            next_cmd = '{addr: ducache_araddr_i, is_line: 1'b0};
        end else begin
            next_cmd = '{addr: icache_rd_addr_i, is_line: 1'b1};
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            busy        <= 1'b0;
            cmd_valid_o <= 1'b0;
            gnt_ic      <= 1'b0;
            gnt_dc      <= 1'b0;
            gnt_du      <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;   // engine is idle whenever we grant
            if (busy) begin
                if (rd_done_i) begin
                    busy   <= 1'b0;
                    gnt_ic <= 1'b0;
                    gnt_dc <= 1'b0;
                    gnt_du <= 1'b0;
                end
            end else if (any_req) begin
                busy        <= 1'b1;
                cmd_valid_o <= 1'b1;
                gnt_dc      <= dcache_rd_req_i;
                gnt_du      <= !dcache_rd_req_i && ducache_ren_i;
                gnt_ic      <= !dcache_rd_req_i && !ducache_ren_i;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!busy && any_req) begin
            cmd_o <= next_cmd;
        end
    end

    assign icache_ret_valid_o = rd_done_i && gnt_ic;
    assign dcache_ret_valid_o = rd_done_i && gnt_dc;
    assign ducache_rvalid_o   = rd_done_i && gnt_du;
    assign icache_ret_data_o  = rd_data_i;
    assign dcache_ret_data_o  = rd_data_i;
    assign ducache_rdata_o    = rd_data_i[word_w-1:0];   // single beat lands in word 0

    // engine completes only a command we issued, so exactly one client gets the pulse
    a_done_in_grant: assert property (@(posedge aclk) disable iff (rst)
        rd_done_i |-> busy && $onehot({gnt_ic, gnt_dc, gnt_du}));

endmodule

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model import mem_bus_pkg::*; (
    input  logic    aclk,
    input  logic    rst,
    input  axi_ar_t ar_i,
    input  logic    arvalid_i,
    output logic    arready_o = 1'b0,
    output axi_r_t  r_o = '0,
    output logic    rvalid_o = 1'b0,
    input  logic    rready_i,
    input  axi_aw_t aw_i,
    input  logic    awvalid_i,
    output logic    awready_o = 1'b0,
    input  axi_w_t  w_i,
    input  logic    wvalid_i,
    output logic    wready_o = 1'b0,
    output logic    bvalid_o = 1'b0,
    input  logic    bready_i
);
    logic [31:0] mem [64];
    logic [31:0] rnd;
    logic        rd_busy, wr_busy, b_pend;
    logic [5:0]  rd_ptr, wr_ptr;
    logic [7:0]  rd_left;          // beats still to send after the current one
    logic        ar_hs = 1'b0, r_hs = 1'b0, aw_hs = 1'b0, w_hs = 1'b0, b_hs = 1'b0;
    axi_ar_t     ar_q;
    axi_aw_t     aw_q;
    axi_w_t      w_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] pattern_word(input logic [5:0] n);
        return {26'd0, n} * 32'h0101_0101 ^ 32'hA5A5_A5A5;
    endfunction

    // handshakes seen on the rising edge, acted on at the falling edge
    always @(posedge aclk) begin
        ar_hs <= arvalid_i && arready_o;
        ar_q  <= ar_i;
        r_hs  <= rvalid_o && rready_i;
        aw_hs <= awvalid_i && awready_o;
        aw_q  <= aw_i;
        w_hs  <= wvalid_i && wready_o;
        w_q   <= w_i;
        b_hs  <= bvalid_o && bready_i;
    end

    always @(negedge aclk) begin
        if (rst) begin
            rnd     = 32'd41647;
            rd_busy = 1'b0;
            wr_busy = 1'b0;
            b_pend  = 1'b0;
            for (int n = 0; n < 64; n++) begin
                mem[6'(n)] = pattern_word(6'(n));
            end
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
        end else begin
            rnd = lcg_next(rnd);
            if (r_hs) begin
                rd_ptr = rd_ptr + 6'd1;
                if (rd_left == 8'd0) begin
                    rd_busy = 1'b0;
                end else begin
                    rd_left = rd_left - 8'd1;
                end
            end
            if (ar_hs) begin
                rd_busy = 1'b1;
                rd_ptr  = ar_q.addr[7:2];
                rd_left = ar_q.len;
            end
            if (w_hs) begin
                for (int k = 0; k < 4; k++) begin
                    if (w_q.strb[k]) begin
                        mem[wr_ptr][8*k +: 8] = w_q.data[8*k +: 8];
                    end
                end
                wr_ptr = wr_ptr + 6'd1;
                b_pend = b_pend || w_q.last;
            end
            if (aw_hs) begin
                wr_busy = 1'b1;
                wr_ptr  = aw_q.addr[7:2];
            end
            if (b_hs) begin
                b_pend  = 1'b0;
                wr_busy = 1'b0;
            end
            arready_o <= !rd_busy && rnd[16];
            awready_o <= !wr_busy && rnd[18];
            wready_o  <= wr_busy && !b_pend && rnd[19];
            bvalid_o  <= b_pend && ((bvalid_o && !b_hs) || rnd[20]);   // held until taken
            if (rd_busy && ((rvalid_o && !r_hs) || rnd[17])) begin
                rvalid_o <= 1'b1;
                r_o      <= '{data: mem[rd_ptr], resp: 2'b00, last: rd_left == 8'd0};
            end else begin
                rvalid_o <= 1'b0;
            end
        end
    end

endmodule

/* verif/mem_bridge_tb.sv */
`timescale 1ns/1ps

module mem_bridge_tb import mem_bus_pkg::*; ();

    typedef enum int {ic_rd, dc_rd, du_rd, dc_wr, du_wr} client_e;

    logic              aclk;
    logic              rst;
    logic              icache_rd_req, dcache_rd_req, ducache_ren;
    logic [addr_w-1:0] icache_rd_addr, dcache_rd_addr, ducache_araddr;
    logic              icache_ret_valid, dcache_ret_valid, ducache_rvalid;
    line_t             icache_ret_data, dcache_ret_data;
    logic [word_w-1:0] ducache_rdata;
    logic              dcache_wr_req, ducache_wen;
    logic [addr_w-1:0] dcache_wr_addr, ducache_awaddr;
    line_t             dcache_wr_data;
    logic [word_w-1:0] ducache_wdata;
    logic [3:0]        ducache_strb;
    logic              dcache_wr_done, ducache_bvalid;
    axi_ar_t           ar;
    axi_aw_t           aw;
    axi_r_t            r;
    axi_w_t            w;
    logic              arvalid, arready, rvalid, rready;
    logic              awvalid, awready, wvalid, wready, bvalid, bready;

    int          errors = 0;
    int          timeouts = 0;
    int          ret_seq = 0;
    int          seq_base;
    logic        rst_q = 1'b0;
    logic [2:0]  w_beat;
    logic [9:0]  ctrl_outs;
    logic [31:0] exp_mem [64];
    line_t       exp_ic_line, exp_dc_line, exp_wline;
    logic [31:0] exp_du_word;
    axi_ar_t     exp_ar;
    axi_aw_t     exp_aw;
    logic [3:0]  exp_strb;
    logic [2:0]  exp_w_last;
    logic        ar_chk, order_chk;

    tb_clock u_clock (.aclk_o(aclk), .rst_o(rst));

    axi_mem_model u_mem (
        .aclk(aclk), .rst(rst),
        .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
        .r_o(r), .rvalid_o(rvalid), .rready_i(rready),
        .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
        .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
        .bvalid_o(bvalid), .bready_i(bready)
    );

    mem_bridge_top dut_i (
        .aclk(aclk), .rst(rst),
        .icache_rd_req_i(icache_rd_req), .icache_rd_addr_i(icache_rd_addr),
        .icache_ret_valid_o(icache_ret_valid), .icache_ret_data_o(icache_ret_data),
        .dcache_rd_req_i(dcache_rd_req), .dcache_rd_addr_i(dcache_rd_addr),
        .dcache_ret_valid_o(dcache_ret_valid), .dcache_ret_data_o(dcache_ret_data),
        .dcache_wr_req_i(dcache_wr_req), .dcache_wr_addr_i(dcache_wr_addr),
        .dcache_wr_data_i(dcache_wr_data), .dcache_wr_done_o(dcache_wr_done),
        .ducache_ren_i(ducache_ren), .ducache_araddr_i(ducache_araddr),
        .ducache_rvalid_o(ducache_rvalid), .ducache_rdata_o(ducache_rdata),
        .ducache_wen_i(ducache_wen), .ducache_awaddr_i(ducache_awaddr),
        .ducache_wdata_i(ducache_wdata), .ducache_strb_i(ducache_strb),
        .ducache_bvalid_o(ducache_bvalid),
        .ar_o(ar), .arvalid_o(arvalid), .arready_i(arready),
        .r_i(r), .rvalid_i(rvalid), .rready_o(rready),
        .aw_o(aw), .awvalid_o(awvalid), .awready_i(awready),
        .w_o(w), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    assign ctrl_outs = {icache_ret_valid, dcache_ret_valid, ducache_rvalid, dcache_wr_done,
                        ducache_bvalid, arvalid, awvalid, wvalid, rready, bready};

    always @(posedge aclk) begin
        rst_q <= rst;
        if (icache_ret_valid || dcache_ret_valid || ducache_rvalid) begin
            ret_seq <= ret_seq + 1;   // read completion order
        end
        if (rst || (awvalid && awready)) begin
            w_beat <= 3'd0;
        end else if (wvalid && wready) begin
            w_beat <= w_beat + 3'd1;
        end
    end

    a_reset_quiet: assert property (@(posedge aclk) rst_q |-> ctrl_outs == 10'd0)
        else begin
            errors++;
            $display("FAIL ctrl_outs got %h expected 000", ctrl_outs);
        end

    a_ic_data: assert property (@(posedge aclk) disable iff (rst)
        icache_ret_valid |-> icache_ret_data == exp_ic_line)
        else begin
            errors++;
            $display("FAIL icache_ret_data_o got %h expected %h", icache_ret_data, exp_ic_line);
        end

    a_dc_data: assert property (@(posedge aclk) disable iff (rst)
        dcache_ret_valid |-> dcache_ret_data == exp_dc_line)
        else begin
            errors++;
            $display("FAIL dcache_ret_data_o got %h expected %h", dcache_ret_data, exp_dc_line);
        end

    a_du_data: assert property (@(posedge aclk) disable iff (rst)
        ducache_rvalid |-> ducache_rdata == exp_du_word)
        else begin
            errors++;
            $display("FAIL ducache_rdata_o got %h expected %h", ducache_rdata, exp_du_word);
        end

    a_ar_fields: assert property (@(posedge aclk) disable iff (rst)
        ar_chk && arvalid |-> ar == exp_ar)
        else begin
            errors++;
            $display("FAIL ar_o got %h expected %h", ar, exp_ar);
        end

    a_aw_fields: assert property (@(posedge aclk) disable iff (rst)
        awvalid |-> aw == exp_aw)
        else begin
            errors++;
            $display("FAIL aw_o got %h expected %h", aw, exp_aw);
        end

    a_w_data: assert property (@(posedge aclk) disable iff (rst)
        wvalid && wready |-> w.data == exp_wline[w_beat*word_w +: word_w])
        else begin
            errors++;
            $display("FAIL w_o.data got %h expected %h", w.data,
                     exp_wline[w_beat*word_w +: word_w]);
        end

    a_w_strb_last: assert property (@(posedge aclk) disable iff (rst)
        wvalid && wready |-> w.strb == exp_strb && w.last == (w_beat == exp_w_last))
        else begin
            errors++;
            $display("FAIL w_o.strb got %h expected %h, w_o.last %h on beat %0d",
                     w.strb, exp_strb, w.last, w_beat);
        end

    // priority order, and a second pulse from any client lands on a wrong slot
    a_dc_first: assert property (@(posedge aclk) disable iff (rst)
        order_chk && dcache_ret_valid |-> ret_seq == seq_base)
        else begin
            errors++;
            $display("dcache refill did not complete first, or completed twice");
        end

    a_du_second: assert property (@(posedge aclk) disable iff (rst)
        order_chk && ducache_rvalid |-> ret_seq == seq_base + 1)
        else begin
            errors++;
            $display("uncached read did not complete second, or completed twice");
        end

    a_ic_third: assert property (@(posedge aclk) disable iff (rst)
        order_chk && icache_ret_valid |-> ret_seq == seq_base + 2)
        else begin
            errors++;
            $display("icache refill did not complete third, or completed twice");
        end

    function automatic logic [31:0] pattern_word(input logic [5:0] n);
        return {26'd0, n} * 32'h0101_0101 ^ 32'hA5A5_A5A5;
    endfunction

    function automatic line_t line_at(input logic [31:0] addr);
        line_t      l;
        logic [5:0] base;
        base = {addr[7:5], 3'b000};
        for (int k = 0; k < line_words; k++) begin
            l[k*word_w +: word_w] = exp_mem[base + 6'(k)];
        end
        return l;
    endfunction

    function automatic logic done_seen(input client_e who);
        case (who)
            ic_rd:   return icache_ret_valid;
            dc_rd:   return dcache_ret_valid;
            du_rd:   return ducache_rvalid;
            dc_wr:   return dcache_wr_done;
            default: return ducache_bvalid;
        endcase
    endfunction

    task automatic end_run();
        $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (rst && n < 20);
        if (rst) begin
            timeouts++;
            $display("timeout: reset was never released");
            end_run();
        end
        @(negedge aclk);
    endtask

    task automatic wait_done(input client_e who, input string what);
        int n;
        n = 0;
        do begin
            @(negedge aclk);
            n++;
        end while (!done_seen(who) && n < 500);
        if (!done_seen(who)) begin
            timeouts++;
            $display("timeout: no %s completion after %0d cycles", what, n);
            end_run();
        end
    endtask

    task automatic icache_read(input logic [31:0] addr);
        exp_ic_line = line_at(addr);
        icache_rd_addr <= addr;
        icache_rd_req  <= 1'b1;
        wait_done(ic_rd, "icache refill");
        icache_rd_req <= 1'b0;
        @(negedge aclk);   // let the pulse be sampled before the next setup
    endtask

    task automatic dcache_read(input logic [31:0] addr);
        exp_dc_line = line_at(addr);
        dcache_rd_addr <= addr;
        dcache_rd_req  <= 1'b1;
        wait_done(dc_rd, "dcache refill");
        dcache_rd_req <= 1'b0;
        @(negedge aclk);
    endtask

    task automatic ducache_read(input logic [31:0] addr);
        exp_du_word = exp_mem[addr[7:2]];
        ducache_araddr <= addr;
        ducache_ren    <= 1'b1;
        wait_done(du_rd, "uncached read");
        ducache_ren <= 1'b0;
        @(negedge aclk);
    endtask

    task automatic dcache_write(input logic [31:0] addr, input line_t data);
        logic [5:0] base;
        base       = {addr[7:5], 3'b000};
        exp_wline  = data;
        exp_strb   = strb_all;
        exp_w_last = 3'(line_words - 1);
        dcache_wr_addr <= addr;
        dcache_wr_data <= data;
        dcache_wr_req  <= 1'b1;
        wait_done(dc_wr, "dcache writeback");
        dcache_wr_req <= 1'b0;
        @(negedge aclk);
        for (int k = 0; k < line_words; k++) begin
            exp_mem[base + 6'(k)] = data[k*word_w +: word_w];
        end
    endtask

    task automatic ducache_write(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb);
        logic [5:0] idx;
        idx        = addr[7:2];
        exp_wline  = '0;
        exp_wline[word_w-1:0] = data;
        exp_strb   = strb;
        exp_w_last = 3'd0;
        ducache_awaddr <= addr;
        ducache_wdata  <= data;
        ducache_strb   <= strb;
        ducache_wen    <= 1'b1;
        wait_done(du_wr, "uncached write");
        ducache_wen <= 1'b0;
        @(negedge aclk);
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                exp_mem[idx][8*k +: 8] = data[8*k +: 8];   // byte merge
            end
        end
    endtask

    initial begin
        line_t wline;
        icache_rd_req  = 1'b0;
        icache_rd_addr = '0;
        dcache_rd_req  = 1'b0;
        dcache_rd_addr = '0;
        ducache_ren    = 1'b0;
        ducache_araddr = '0;
        dcache_wr_req  = 1'b0;
        dcache_wr_addr = '0;
        dcache_wr_data = '0;
        ducache_wen    = 1'b0;
        ducache_awaddr = '0;
        ducache_wdata  = '0;
        ducache_strb   = '0;
        ar_chk      = 1'b0;
        order_chk   = 1'b0;
        seq_base    = 0;
        exp_ic_line = '0;
        exp_dc_line = '0;
        exp_du_word = '0;
        exp_wline   = '0;
        exp_strb    = '0;
        exp_w_last  = '0;
        exp_ar      = '0;
        exp_aw      = '0;
        for (int n = 0; n < 64; n++) begin
            exp_mem[6'(n)] = pattern_word(6'(n));
        end
        for (int k = 0; k < line_words; k++) begin
            wline[k*word_w +: word_w] = 32'hD00D_0000 + 32'(k) * 32'h0000_1111;
        end
        wait_reset_release();

        // line refill, offset bits dropped
        ar_chk = 1'b1;
        exp_ar = '{addr: 32'h0000_0060, len: line_len, size: beat_size, burst: burst_incr};
        icache_read(32'h0000_0064);

        exp_ar = '{addr: 32'h0000_0014, len: word_len, size: beat_size, burst: burst_incr};
        ducache_read(32'h0000_0014);

        // writeback then refill of the same line
        exp_aw = '{addr: 32'h0000_0040, len: line_len, size: beat_size, burst: burst_incr};
        dcache_write(32'h0000_0044, wline);
        exp_ar = '{addr: 32'h0000_0040, len: line_len, size: beat_size, burst: burst_incr};
        dcache_read(32'h0000_0044);

        // partial strobe, bytes 0 and 2
        exp_aw = '{addr: 32'h0000_0088, len: word_len, size: beat_size, burst: burst_incr};
        ducache_write(32'h0000_0088, 32'h1122_3344, 4'b0101);
        exp_ar = '{addr: 32'h0000_0088, len: word_len, size: beat_size, burst: burst_incr};
        ducache_read(32'h0000_0088);

        // three readers at once
        ar_chk    = 1'b0;
        seq_base  = ret_seq;
        order_chk = 1'b1;
        fork
            dcache_read(32'h0000_0020);
            ducache_read(32'h0000_0088);
            icache_read(32'h0000_00C8);
        join
        repeat (20) @(negedge aclk);   // catch any stray completion
        end_run();
    end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic aclk_o,
    output logic rst_o
);
    initial begin
        aclk_o = 1'b0;
        forever #10 aclk_o = ~aclk_o;   // 20 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge aclk_o);
        @(negedge aclk_o);
        rst_o <= 1'b0;
    end

endmodule

/* verilog.f */
src/mem_bus_pkg.sv
src/read_arbiter.sv
src/axi_read_engine.sv
src/axi_write_engine.sv
src/mem_bridge_top.sv
verif/tb_clock.sv
verif/axi_mem_model.sv
verif/mem_bridge_tb.sv
